// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= ssds_tb
FILELIST ?= src.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -Wno-fatal -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "TEST PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/ssds_checker.sv ====
module ssds_checker (
	input  logic                display_en,
	input  ssds_pkg::segments_t digit_0,
	input  ssds_pkg::segments_t digit_1,
	input  ssds_pkg::segments_t digit_2,
	input  ssds_pkg::segments_t digit_3,
	input  logic [3:0]          dots,
	output int                  errors
);

	int test_errors;
	int tests_run;

	initial begin
		errors = 0;
		test_errors = 0;
		tests_run = 0;
	end

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
			errors++;
			test_errors++;
		end
	endtask

	// display ports are compared against the expected levels from the model.
	task automatic check_display(input logic exp_en, input logic [6:0] exp_d0,
		input logic [6:0] exp_d1, input logic [6:0] exp_d2, input logic [6:0] exp_d3,
		input logic [3:0] exp_dots);
		check_value("display_en", {31'd0, exp_en}, {31'd0, display_en});
		check_value("digit_0", {25'd0, exp_d0}, {25'd0, digit_0});
		check_value("digit_1", {25'd0, exp_d1}, {25'd0, digit_1});
		check_value("digit_2", {25'd0, exp_d2}, {25'd0, digit_2});
		check_value("digit_3", {25'd0, exp_d3}, {25'd0, digit_3});
		check_value("dots", {28'd0, exp_dots}, {28'd0, dots});
	endtask

	task automatic end_test(input string name);
		if (test_errors == 0) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: failed with %0d errors", name, test_errors);
		end
		tests_run++;
		test_errors = 0;
	endtask

	task automatic summary();
		$display("%0d tests run, %0d errors", tests_run, errors);
	endtask

endmodule

// ==== bench/ssds_tb.sv ====
`include "ssds_params.svh"

module ssds_tb;

	logic clk;
	logic rst;
	ssds_pkg::bus_addr_t m0_addr, m1_addr;
	ssds_pkg::bus_data_t m0_wdata, m1_wdata, m_rdata;
	ssds_pkg::bus_mask_t m0_mask, m1_mask;
	logic m0_rd, m0_wr, m0_fc, m1_rd, m1_wr, m1_fc;
	logic display_en;
	ssds_pkg::segments_t digit_0, digit_1, digit_2, digit_3;
	logic [3:0] dots;
	int errors;
	logic [31:0] rng;
	logic [7:0] ctrl_m;
	logic [7:0] dots_m;
	logic [7:0] digits_m [4];
	int order [$];
	int last_served;

	ssds_top dut_i (.*);

	ssds_checker checker_i (
		.display_en (display_en),
		.digit_0    (digit_0),
		.digit_1    (digit_1),
		.digit_2    (digit_2),
		.digit_3    (digit_3),
		.dots       (dots),
		.errors     (errors)
	);

	always #2 clk = !clk;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function logic [31:0] rand32();
		rng = xorshift(rng);
		return rng;
	endfunction

	// standard hex font with bit 0 as segment a.
	function automatic logic [6:0] hex_seg(input logic [3:0] n);
		logic [6:0] font [16];
		font = '{7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07,
			7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71};
		return font[n];
	endfunction

	function automatic logic [6:0] exp_seg(input logic [7:0] b);
		return b[7] ? hex_seg(b[3:0]) : b[6:0];
	endfunction

	function automatic logic [31:0] model_read(input logic [31:0] addr);
		logic [31:0] word;
		word = '0;
		case ({addr[31:2], 2'b00})
			`SSDS_CTRL_ADDR: word = {24'd0, ctrl_m};
			`SSDS_DIGITS_ADDR: word = {digits_m[3], digits_m[2], digits_m[1], digits_m[0]};
			default: word = {24'd0, dots_m};
		endcase
		return word >> (8 * addr[1:0]);
	endfunction

	task automatic model_write(input logic [31:0] addr, input logic [31:0] data,
		input logic [3:0] mask);
		int off;
		off = addr[1:0];
		case ({addr[31:2], 2'b00})
			`SSDS_CTRL_ADDR: if (off == 0 && mask[0]) ctrl_m = data[7:0];
			`SSDS_DOTS_ADDR: if (off == 0 && mask[0]) dots_m = data[7:0];
			default: begin
				for (int i = 0; i < 4; i++) begin
					if (mask[i] && i + off < 4) digits_m[i + off] = data[8*i +: 8]; // lanes shift up.
				end
			end
		endcase
	endtask

	task automatic drive(input int m, input logic rd, input logic wr, input logic [31:0] addr,
		input logic [31:0] data, input logic [3:0] mask);
		if (m == 0) begin
			m0_rd <= rd;
			m0_wr <= wr;
			m0_addr <= addr;
			m0_wdata <= data;
			m0_mask <= mask;
		end else begin
			m1_rd <= rd;
			m1_wr <= wr;
			m1_addr <= addr;
			m1_wdata <= data;
			m1_mask <= mask;
		end
	endtask

	// one bus transfer; the model is updated when fc is seen.
	task automatic transfer(input int m, input logic is_wr, input logic [31:0] addr,
		input logic [31:0] data, input logic [3:0] mask, output logic [31:0] rdata,
		output logic [31:0] exp, output int cycles);
		int n;
		logic seen;
		n = 0;
		seen = 1'b0;
		@(posedge clk);
		drive(m, !is_wr, is_wr, addr, data, mask);
		while (!seen && n <= 20) begin
			@(negedge clk);
			n++;
			seen = (m == 0 && m0_fc) || (m == 1 && m1_fc);
		end
		if (!seen) begin
			$display("timeout: master %0d saw no fc within %0d cycles", m, n);
			$display("TEST FAIL");
			$finish;
		end else begin
			rdata = m_rdata;
			exp = model_read(addr);
			cycles = n;
			if (is_wr) model_write(addr, data, mask);
			order.push_back(m);
			last_served = m;
			@(posedge clk);
			drive(m, 1'b0, 1'b0, '0, '0, '0);
		end
	endtask

	task automatic check_outputs();
		@(negedge clk);
		checker_i.check_display(ctrl_m[0], exp_seg(digits_m[0]), exp_seg(digits_m[1]),
			exp_seg(digits_m[2]), exp_seg(digits_m[3]), dots_m[3:0]);
	endtask

	function automatic logic [31:0] reg_addr(input logic [31:0] r);
		case (r % 3)
			0: return `SSDS_CTRL_ADDR;
			1: return `SSDS_DIGITS_ADDR;
			default: return `SSDS_DOTS_ADDR;
		endcase
	endfunction

	initial begin
		logic [31:0] rdata, exp, addr;
		int cyc, cyc0, cyc1, m, winner, base0, base1, n;
		logic wr0, wr1;
		logic [31:0] rd0, rd1, ex0, ex1;
		clk = 1'b0;
		rst = 1'b1;
		rng = 32'hf1cd60ed;
		last_served = 0;
		ctrl_m = '0;
		dots_m = '0;
		for (int i = 0; i < 4; i++) digits_m[i] = '0;
		drive(0, 1'b0, 1'b0, '0, '0, '0);
		drive(1, 1'b0, 1'b0, '0, '0, '0);
		n = 0;
		while (n < 4) begin
			@(posedge clk);
			n++;
		end
		rst <= 1'b0;

		check_outputs();
		checker_i.check_value("m0_fc", 0, {31'd0, m0_fc});
		checker_i.check_value("m1_fc", 0, {31'd0, m1_fc});
		checker_i.check_value("m_rdata", 0, m_rdata);
		for (int r = 0; r < 3; r++) begin
			transfer(r % 2, 1'b0, reg_addr(r), '0, '0, rdata, exp, cyc);
			checker_i.check_value("m_rdata", 0, rdata);
		end
		checker_i.end_test("reset");

		for (int i = 0; i < 12; i++) begin
			addr = reg_addr(rand32());
			transfer(rand32() % 2, 1'b1, addr, rand32(), 4'hf, rdata, exp, cyc);
			transfer(rand32() % 2, 1'b0, addr, '0, '0, rdata, exp, cyc);
			checker_i.check_value("m_rdata", exp, rdata);
			check_outputs();
		end
		checker_i.end_test("full writes");

		for (int i = 0; i < 16; i++) begin
			addr = `SSDS_DIGITS_ADDR + (rand32() % 4);
			transfer(rand32() % 2, 1'b1, addr, rand32(), rand32() % 16, rdata, exp, cyc);
			addr = `SSDS_DIGITS_ADDR + (rand32() % 4);
			transfer(rand32() % 2, 1'b0, addr, '0, '0, rdata, exp, cyc);
			checker_i.check_value("m_rdata", exp, rdata);
			check_outputs();
		end
		checker_i.end_test("offset writes");

		for (int i = 0; i < 16; i++) begin
			transfer(rand32() % 2, 1'b1, `SSDS_DIGITS_ADDR, rand32(), 4'hf, rdata, exp, cyc);
			check_outputs();
		end
		checker_i.end_test("digit decode");

		for (int i = 0; i < 8; i++) begin
			// a single read from a random master sets who was served last.
			transfer(rand32() % 2, 1'b0, `SSDS_CTRL_ADDR, '0, '0, rdata, exp, cyc);
			checker_i.check_value("m_rdata", exp, rdata);
			winner = 1 - last_served;
			wr0 = rand32() % 2;
			wr1 = rand32() % 2;
			base0 = wr0 ? 3 : 2;
			base1 = wr1 ? 3 : 2;
			order.delete();
			fork
				transfer(0, wr0, reg_addr(rand32()), rand32(), 4'hf, rd0, ex0, cyc0);
				transfer(1, wr1, reg_addr(rand32()), rand32(), 4'hf, rd1, ex1, cyc1);
			join
			checker_i.check_value("first fc master", winner, order[0]);
			checker_i.check_value("m0 fc latency", winner == 0 ? base0 : base1 + base0, cyc0);
			checker_i.check_value("m1 fc latency", winner == 1 ? base1 : base0 + base1, cyc1);
			if (!wr0) checker_i.check_value("m_rdata", ex0, rd0);
			if (!wr1) checker_i.check_value("m_rdata", ex1, rd1);
			check_outputs();
		end
		checker_i.end_test("arbitration");

		for (int i = 0; i < 10; i++) begin
			m = rand32() % 2;
			addr = reg_addr(rand32()) + (rand32() % 4);
			transfer(m, 1'b0, addr, '0, '0, rdata, exp, cyc);
			checker_i.check_value("read fc latency", 2, cyc);
			checker_i.check_value("m_rdata", exp, rdata);
		end
		checker_i.end_test("read latency");

		checker_i.summary();
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+src
src/ssds_pkg.sv
src/ssds_digit_mapper.sv
src/ssds_bus_interface.sv
src/ssds_bus_arbiter.sv
src/ssds_top.sv
bench/ssds_checker.sv
bench/ssds_tb.sv

// ==== src/ssds_bus_arbiter.sv ====
module ssds_bus_arbiter (
	input  logic                clk,
	input  logic                rst,
	input  ssds_pkg::bus_addr_t m0_addr,
	input  ssds_pkg::bus_data_t m0_wdata,
	input  ssds_pkg::bus_mask_t m0_mask,
	input  logic                m0_rd,
	input  logic                m0_wr,
	output logic                m0_fc,
	input  ssds_pkg::bus_addr_t m1_addr,
	input  ssds_pkg::bus_data_t m1_wdata,
	input  ssds_pkg::bus_mask_t m1_mask,
	input  logic                m1_rd,
	input  logic                m1_wr,
	output logic                m1_fc,
	output ssds_pkg::bus_addr_t bus_addr,
	output ssds_pkg::bus_data_t bus_wdata,
	output ssds_pkg::bus_mask_t bus_mask,
	output logic                bus_rd,
	output logic                bus_wr,
	input  logic                bus_fc
);

	ssds_pkg::arb_state_t state_q;
	logic grant_q;
	logic last_q;
	logic m0_req;
	logic m1_req;
	logic pick;
	logic busy;

	assign m0_req = m0_rd || m0_wr;
	assign m1_req = m1_rd || m1_wr;
	assign busy = state_q == ssds_pkg::arb_busy;

	// on a tie the master not served last wins.
	assign pick = (m0_req && m1_req) ? !last_q : m1_req;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state_q <= ssds_pkg::arb_idle;
			grant_q <= 1'b0;
			last_q <= 1'b0; // master 1 takes the first tie.
		end else begin
			case (state_q)
				ssds_pkg::arb_idle: begin
					if (m0_req || m1_req) begin
						state_q <= ssds_pkg::arb_busy;
						grant_q <= pick;
					end
				end
				default: begin
					if (bus_fc) begin
						state_q <= ssds_pkg::arb_idle;
						last_q <= grant_q;
					end
				end
			endcase
		end
	end

	always_comb begin
		bus_addr = '0;
		bus_wdata = '0;
		bus_mask = '0;
		bus_rd = 1'b0;
		bus_wr = 1'b0;
		if (busy && grant_q) begin
			bus_addr = m1_addr;
			bus_wdata = m1_wdata;
			bus_mask = m1_mask;
			bus_rd = m1_rd;
			bus_wr = m1_wr;
		end else if (busy) begin
			bus_addr = m0_addr;
			bus_wdata = m0_wdata;
			bus_mask = m0_mask;
			bus_rd = m0_rd;
			bus_wr = m0_wr;
		end
	end

	assign m0_fc = busy && !grant_q && bus_fc;
	assign m1_fc = busy && grant_q && bus_fc;

endmodule

// ==== src/ssds_bus_interface.sv ====
`include "ssds_params.svh"

module ssds_bus_interface (
	input  logic                clk,
	input  logic                rst,
	input  ssds_pkg::bus_addr_t bus_addr,
	input  ssds_pkg::bus_data_t bus_wdata,
	input  ssds_pkg::bus_mask_t bus_mask,
	input  logic                bus_rd,
	input  logic                bus_wr,
	output ssds_pkg::bus_data_t bus_rdata,
	output logic                bus_fc,
	output logic                display_en,
	output ssds_pkg::segments_t digit_0,
	output ssds_pkg::segments_t digit_1,
	output ssds_pkg::segments_t digit_2,
	output ssds_pkg::segments_t digit_3,
	output logic [3:0]          dots
);

	logic [7:0] ctrl_q;
	logic [7:0] dots_q;
	ssds_pkg::digit_t digits_q [4];
	ssds_pkg::segments_t mapped [4];
	ssds_pkg::segments_t shown [4];
	ssds_pkg::bus_data_t reg_word;
	ssds_pkg::bus_addr_t word_addr;
	logic [1:0] offset;
	logic sel_ctrl;
	logic sel_digits;
	logic sel_dots;
	logic addr_hit;
	logic read_req;
	logic write_req;
	logic written_q;

	assign offset = bus_addr[1:0];
	assign word_addr = {bus_addr[`SSDS_ADDR_W-1:2], 2'b00};

	assign sel_ctrl = word_addr == `SSDS_CTRL_ADDR;
	assign sel_digits = word_addr == `SSDS_DIGITS_ADDR;
	assign sel_dots = word_addr == `SSDS_DOTS_ADDR;
	assign addr_hit = sel_ctrl || sel_digits || sel_dots;

	// exactly one strobe must be up for a valid request.
	assign read_req = addr_hit && bus_rd && !bus_wr;
	assign write_req = addr_hit && bus_wr && !bus_rd;

	// reads finish at once, writes one cycle after the register update.
	assign bus_fc = read_req || (write_req && written_q);

	for (genvar i = 0; i < 4; i++) begin : g_digit
		ssds_digit_mapper mapper_i (
			.digit    (digits_q[i]),
			.segments (mapped[i])
		);

		assign shown[i] = digits_q[i][7] ? mapped[i] : digits_q[i][6:0]; // raw segments when clear.
	end

	assign digit_0 = shown[0];
	assign digit_1 = shown[1];
	assign digit_2 = shown[2];
	assign digit_3 = shown[3];
	assign dots = dots_q[3:0];
	assign display_en = ctrl_q[0];

	always_comb begin
		reg_word = '0;
		if (sel_ctrl) begin
			reg_word[7:0] = ctrl_q;
		end else if (sel_digits) begin
			reg_word = {digits_q[3], digits_q[2], digits_q[1], digits_q[0]};
		end else if (sel_dots) begin
			reg_word[7:0] = dots_q;
		end
	end

	assign bus_rdata = read_req ? (reg_word >> {offset, 3'b000}) : '0; // zero fill from the top.

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			written_q <= 1'b0;
			ctrl_q <= '0;
			dots_q <= '0;
			for (int i = 0; i < 4; i++) begin
				digits_q[i] <= '0;
			end
		end else begin
			written_q <= write_req && !written_q;
			if (write_req && !written_q) begin
				if (sel_ctrl && offset == 2'd0 && bus_mask[0]) begin
					ctrl_q <= bus_wdata[7:0];
				end
				if (sel_dots && offset == 2'd0 && bus_mask[0]) begin
					dots_q <= bus_wdata[7:0];
				end
				// lane i lands on byte i + offset, anything past byte 3 is dropped.
				if (sel_digits) begin
					for (int i = 0; i < 4; i++) begin
						if (bus_mask[i] && (i + offset) < 4) begin
							digits_q[i + offset] <= bus_wdata[8*i +: 8];
						end
					end
				end
			end
		end
	end

endmodule

// ==== src/ssds_digit_mapper.sv ====
module ssds_digit_mapper (
	input  ssds_pkg::digit_t    digit,
	output ssds_pkg::segments_t segments
);

	// segment order is {g, f, e, d, c, b, a}.
	always_comb begin
		case (digit[3:0])
			4'h0: segments = 7'h3f;
			4'h1: segments = 7'h06;
			4'h2: segments = 7'h5b;
			4'h3: segments = 7'h4f;
			4'h4: segments = 7'h66;
			4'h5: segments = 7'h6d;
			4'h6: segments = 7'h7d;
			4'h7: segments = 7'h07;
			4'h8: segments = 7'h7f;
			4'h9: segments = 7'h6f;
			4'ha: segments = 7'h77; // upper case A.
			4'hb: segments = 7'h7c; // lower case b.
			4'hc: segments = 7'h39;
			4'hd: segments = 7'h5e; // lower case d.
			4'he: segments = 7'h79;
			default: segments = 7'h71; // F.
		endcase
	end

endmodule

// ==== src/ssds_params.svh ====
`ifndef SSDS_PARAMS_SVH
`define SSDS_PARAMS_SVH

// bus widths.
`define SSDS_ADDR_W 32
`define SSDS_DATA_W 32

// register map, word aligned.
`define SSDS_CTRL_ADDR   32'h0000_0000
`define SSDS_DIGITS_ADDR 32'h0000_0004
`define SSDS_DOTS_ADDR   32'h0000_0008

`endif

// ==== src/ssds_pkg.sv ====
`include "ssds_params.svh"

package ssds_pkg;

	typedef logic [`SSDS_ADDR_W-1:0] bus_addr_t;
	typedef logic [`SSDS_DATA_W-1:0] bus_data_t;
	typedef logic [`SSDS_DATA_W/8-1:0] bus_mask_t; // one enable per byte lane.

	// bit 7 set means the low nibble is shown as a hex digit.
	typedef logic [7:0] digit_t;

	// bit 0 is segment a, bit 6 is segment g, active high.
	typedef logic [6:0] segments_t;

	typedef enum logic {
		arb_idle,
		arb_busy
	} arb_state_t;

endpackage

// ==== src/ssds_top.sv ====
module ssds_top (
	input  logic                clk,
	input  logic                rst,
	input  ssds_pkg::bus_addr_t m0_addr,
	input  ssds_pkg::bus_data_t m0_wdata,
	input  ssds_pkg::bus_mask_t m0_mask,
	input  logic                m0_rd,
	input  logic                m0_wr,
	output logic                m0_fc,
	input  ssds_pkg::bus_addr_t m1_addr,
	input  ssds_pkg::bus_data_t m1_wdata,
	input  ssds_pkg::bus_mask_t m1_mask,
	input  logic                m1_rd,
	input  logic                m1_wr,
	output logic                m1_fc,
	output ssds_pkg::bus_data_t m_rdata,
	output logic                display_en,
	output ssds_pkg::segments_t digit_0,
	output ssds_pkg::segments_t digit_1,
	output ssds_pkg::segments_t digit_2,
	output ssds_pkg::segments_t digit_3,
	output logic [3:0]          dots
);

	ssds_pkg::bus_addr_t bus_addr;
	ssds_pkg::bus_data_t bus_wdata;
	ssds_pkg::bus_mask_t bus_mask;
	logic bus_rd;
	logic bus_wr;
	logic bus_fc;

	ssds_bus_arbiter arbiter_i (
		.clk       (clk),
		.rst       (rst),
		.m0_addr   (m0_addr),
		.m0_wdata  (m0_wdata),
		.m0_mask   (m0_mask),
		.m0_rd     (m0_rd),
		.m0_wr     (m0_wr),
		.m0_fc     (m0_fc),
		.m1_addr   (m1_addr),
		.m1_wdata  (m1_wdata),
		.m1_mask   (m1_mask),
		.m1_rd     (m1_rd),
		.m1_wr     (m1_wr),
		.m1_fc     (m1_fc),
		.bus_addr  (bus_addr),
		.bus_wdata (bus_wdata),
		.bus_mask  (bus_mask),
		.bus_rd    (bus_rd),
		.bus_wr    (bus_wr),
		.bus_fc    (bus_fc)
	);

	// read data is shared by both masters.
	ssds_bus_interface periph_i (
		.clk        (clk),
		.rst        (rst),
		.bus_addr   (bus_addr),
		.bus_wdata  (bus_wdata),
		.bus_mask   (bus_mask),
		.bus_rd     (bus_rd),
		.bus_wr     (bus_wr),
		.bus_rdata  (m_rdata),
		.bus_fc     (bus_fc),
		.display_en (display_en),
		.digit_0    (digit_0),
		.digit_1    (digit_1),
		.digit_2    (digit_2),
		.digit_3    (digit_3),
		.dots       (dots)
	);

endmodule
